// File: sim.f
design/cpuPkg.sv
design/busPkg.sv
design/debugPort.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memoryStage.sv
design/pipelineCpu.sv
tb/cpuTb.sv

// File: Makefile
# Verilator flow for the pipelined CPU testbench
VERILATOR  ?= verilator
TOP        ?= cpuTb
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LINT_FLAGS ?= --timing --assert
SIM_FLAGS  ?= --timing --assert -Wno-fatal
PASS_MSG   ?= All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	out="$$(./$(BUILD_DIR)/$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: tb/cpuTb.sv
`timescale 1ns/10ps

module cpuTb
  import cpuPkg::*;
  import busPkg::*;
();
  localparam int MaxWait  = 50;   // cycles per handshake phase
  localparam int MaxPolls = 100;  // status reads per program

  logic          clk;
  logic          rst;
  axiLiteReq_t   busReq;
  axiLiteRsp_t   busRsp;
  logic [15:0]   lfsr;
  logic [31:0]   progQ [$];   // program words, loaded from index 0
  int            errCount;
  int            testCount;
  int            failedTests;

  pipelineCpu #(.ImemDepth(64), .DmemDepth(32)) i_dut (.clk, .rst, .busReq, .busRsp);

  always #5 clk = ~clk;  // 10 ns period

  // ----------------------------------------
  // encoders and random source
  // ----------------------------------------
  function automatic logic [31:0] encR(input logic [4:0] rs, input logic [4:0] rt,
                                       input logic [4:0] rd, input funct_t fn);
    return {opRType, rs, rt, rd, 5'd0, fn};
  endfunction

  function automatic logic [31:0] encI(input opcode_t op, input logic [4:0] rs,
                                       input logic [4:0] rt, input logic [15:0] imm);
    return {op, rs, rt, imm};
  endfunction

  function automatic logic [31:0] sext16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  // fibonacci, x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic randBits(input int n, output logic [15:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr);  // one step per bit
      v    = {v[14:0], lfsr[0]};
    end
  endtask

  // ----------------------------------------
  // reporting
  // ----------------------------------------
  task automatic finishRun();
    $display("%0d tests run, %0d failed, %0d errors", testCount, failedTests, errCount);
    if (errCount == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  endtask

  task automatic timeoutAbort(input string what, input int tries);
    $display("Timeout at %0t: no %s after %0d tries, stopping", $time, what, tries);
    errCount++;
    finishRun();
  endtask

  task automatic checkEq(input string what, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s read %h, expected %h", $time, what, got, exp);
      errCount++;
    end
  endtask

  task automatic testDone(input string name, input int errsAtStart);
    testCount++;
    if (errCount == errsAtStart) begin
      $display("[%0t] %s: pass", $time, name);
    end else begin
      failedTests++;
      $display("[%0t] %s: FAIL with %0d errors", $time, name, errCount - errsAtStart);
    end
  endtask

  // ----------------------------------------
  // AXI4-Lite master
  // ----------------------------------------
  task automatic axiWrite(input logic [15:0] addr, input logic [31:0] data);
    int waitCnt;
    @(posedge clk);
    busReq.awaddr  <= addr;
    busReq.awvalid <= 1'b1;
    busReq.wdata   <= data;
    busReq.wstrb   <= 4'hf;
    busReq.wvalid  <= 1'b1;
    waitCnt = 0;
    @(negedge clk);  // sample mid-cycle
    while (!busRsp.awready) begin
      if (waitCnt == MaxWait) timeoutAbort("write accept", MaxWait);
      waitCnt++;
      @(negedge clk);
    end
    checkEq("wready", 32'(busRsp.wready), 32'd1);  // both channels in one cycle
    @(posedge clk);  // accepted here
    busReq.awvalid <= 1'b0;
    busReq.wvalid  <= 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while (!busRsp.bvalid) begin
      if (waitCnt == MaxWait) timeoutAbort("write response", MaxWait);
      waitCnt++;
      @(negedge clk);
    end
    checkEq("bresp", 32'(busRsp.bresp), 32'(RespOkay));
    @(posedge clk);  // bready always high
  endtask

  task automatic axiRead(input logic [15:0] addr, output logic [31:0] data,
                         output logic [1:0] resp);
    int waitCnt;
    @(posedge clk);
    busReq.araddr  <= addr;
    busReq.arvalid <= 1'b1;
    waitCnt = 0;
    @(negedge clk);
    while (!busRsp.arready) begin
      if (waitCnt == MaxWait) timeoutAbort("read accept", MaxWait);
      waitCnt++;
      @(negedge clk);
    end
    @(posedge clk);
    busReq.arvalid <= 1'b0;
    waitCnt = 0;
    @(negedge clk);
    while (!busRsp.rvalid) begin
      if (waitCnt == MaxWait) timeoutAbort("read data", MaxWait);
      waitCnt++;
      @(negedge clk);
    end
    data = busRsp.rdata;
    resp = busRsp.rresp;
    @(posedge clk);  // rready always high
  endtask

  task automatic checkWord(input string what, input logic [15:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    logic [1:0]  resp;
    axiRead(addr, got, resp);
    checkEq(what, got, exp);
  endtask

  task automatic checkReg(input int idx, input logic [31:0] exp);
    checkWord($sformatf("r%0d", idx), RegBase + 16'(idx * 4), exp);
  endtask

  // ----------------------------------------
  // program load and run
  // ----------------------------------------
  task automatic loadProgram();
    foreach (progQ[i]) axiWrite(ImemBase + 16'(i * 4), progQ[i]);
    progQ.delete();
  endtask

  task automatic runProgram();
    logic [31:0] status;
    logic [1:0]  resp;
    int          polls;
    axiWrite(CtrlAddr, 32'd1);
    polls = 0;
    axiRead(StatusAddr, status, resp);
    while (status[0] !== 1'b1) begin
      if (polls == MaxPolls) timeoutAbort("halt from the program", MaxPolls);
      polls++;
      axiRead(StatusAddr, status, resp);
    end
    axiWrite(CtrlAddr, 32'd0);  // core back in reset, state kept
  endtask

  // ----------------------------------------
  // directed tests
  // ----------------------------------------
  task automatic testBusBasics();
    int          errsAtStart;
    logic [31:0] got;
    logic [1:0]  resp;
    errsAtStart = errCount;
    checkWord("status after reset", StatusAddr, 32'd0);
    checkWord("cycle count after reset", CycleAddr, 32'd0);
    axiRead(16'h5000, got, resp);  // no region there
    checkEq("unmapped read", got, 32'd0);
    checkEq("unmapped rresp", 32'(resp), 32'(RespOkay));
    checkWord("unmapped ctrl word", 16'h000c, 32'd0);
    testDone("bus basics", errsAtStart);
  endtask

  task automatic testArith();
    int          errsAtStart;
    logic [15:0] immA;
    logic [15:0] immB;
    logic [31:0] exp [1:8];
    errsAtStart = errCount;
    randBits(16, immA);
    randBits(16, immB);
    exp[1] = sext16(immA);
    exp[2] = exp[1] + sext16(immB);
    exp[3] = exp[2] + exp[1];
    exp[4] = exp[3] - exp[1];
    exp[5] = exp[4] & exp[3];
    exp[6] = exp[5] | exp[1];
    exp[7] = ($signed(exp[6]) < $signed(exp[2])) ? 32'd1 : 32'd0;
    exp[8] = exp[7];  // r0 still zero
    progQ.push_back(encI(opAddi, 0, 1, immA));
    progQ.push_back(encI(opAddi, 1, 2, immB));   // each uses the one before
    progQ.push_back(encR(2, 1, 3, fnAdd));
    progQ.push_back(encR(3, 1, 4, fnSub));
    progQ.push_back(encR(4, 3, 5, fnAnd));
    progQ.push_back(encR(5, 1, 6, fnOr));
    progQ.push_back(encR(6, 2, 7, fnSlt));
    progQ.push_back(encI(opAddi, 0, 0, 16'h00ff));  // write to r0
    progQ.push_back(encR(0, 7, 8, fnAdd));
    progQ.push_back({opHalt, 26'd0});
    loadProgram();
    runProgram();
    for (int i = 1; i <= 8; i++) checkReg(i, exp[i]);
    checkReg(0, 32'd0);
    testDone("arithmetic chain", errsAtStart);
  endtask

  task automatic testLoadUse();
    int          errsAtStart;
    logic [15:0] immA;
    logic [15:0] immB;
    logic [31:0] va;
    logic [31:0] vb;
    logic [31:0] pre;
    errsAtStart = errCount;
    randBits(16, immA);
    randBits(16, immB);
    va  = sext16(immA);
    vb  = sext16(immB);
    pre = {immB, immA};
    axiWrite(DmemBase, pre);  // preload word 0 while stopped
    progQ.push_back(encI(opAddi, 0, 1, immA));
    progQ.push_back(encI(opAddi, 0, 2, immB));
    progQ.push_back(encI(opSw, 0, 1, 16'd8));
    progQ.push_back(encI(opSw, 0, 2, 16'd12));
    progQ.push_back(encI(opLw, 0, 3, 16'd8));
    progQ.push_back(encI(opLw, 0, 4, 16'd12));
    progQ.push_back(encR(3, 4, 5, fnAdd));      // load-use on r4
    progQ.push_back(encI(opSw, 0, 5, 16'd16));
    progQ.push_back(encI(opLw, 0, 6, 16'd16));
    progQ.push_back(encR(6, 6, 7, fnAdd));      // load-use on r6
    progQ.push_back(encI(opLw, 0, 8, 16'd0));
    progQ.push_back(encR(8, 1, 9, fnAdd));
    progQ.push_back({opHalt, 26'd0});
    loadProgram();
    runProgram();
    checkReg(3, va);
    checkReg(4, vb);
    checkReg(5, va + vb);
    checkReg(6, va + vb);
    checkReg(7, (va + vb) + (va + vb));
    checkReg(8, pre);
    checkReg(9, pre + va);
    checkWord("dmem[2]", DmemBase + 16'd8, va);
    checkWord("dmem[3]", DmemBase + 16'd12, vb);
    checkWord("dmem[4]", DmemBase + 16'd16, va + vb);
    testDone("load-use", errsAtStart);
  endtask

  task automatic testBranch();
    int          errsAtStart;
    logic [15:0] rnd;
    logic [15:0] n;
    errsAtStart = errCount;
    randBits(3, rnd);
    n = 16'd3 + rnd;  // 3 to 10 passes
    progQ.push_back(encI(opAddi, 0, 4, 16'h0011));  // markers, old values
    progQ.push_back(encI(opAddi, 0, 5, 16'h0022));
    progQ.push_back(encI(opAddi, 0, 1, n));
    progQ.push_back(encI(opAddi, 0, 2, 16'd0));
    progQ.push_back(encI(opAddi, 2, 2, 16'd1));     // loop body at 4
    progQ.push_back(encI(opAddi, 1, 1, 16'hffff));
    progQ.push_back(encI(opBne, 1, 0, 16'hfffd));   // back to 4
    progQ.push_back(encI(opBeq, 1, 0, 16'd1));      // taken, skips 8
    progQ.push_back(encI(opAddi, 0, 4, 16'h0055));
    progQ.push_back({opJ, 26'd11});
    progQ.push_back(encI(opAddi, 0, 5, 16'h0066));
    progQ.push_back(encI(opAddi, 2, 6, 16'h0100));
    progQ.push_back({opHalt, 26'd0});
    loadProgram();
    runProgram();
    checkReg(1, 32'd0);
    checkReg(2, 32'(n));
    checkReg(4, 32'h11);  // squashed after beq
    checkReg(5, 32'h22);  // squashed after j
    checkReg(6, 32'(n) + 32'h100);
    testDone("branches and jump", errsAtStart);
  endtask

  task automatic testHalt();
    int          errsAtStart;
    logic [31:0] c1;
    logic [31:0] c2;
    logic [1:0]  resp;
    errsAtStart = errCount;
    progQ.push_back(encI(opAddi, 0, 10, 16'h1234));
    progQ.push_back(encI(opAddi, 0, 11, 16'h0042));
    progQ.push_back({opHalt, 26'd0});
    progQ.push_back(encI(opAddi, 0, 10, 16'h7777));  // never reached
    progQ.push_back(encI(opAddi, 0, 11, 16'h0999));
    loadProgram();
    runProgram();
    checkReg(10, 32'h1234);
    checkReg(11, 32'h42);
    axiRead(CycleAddr, c1, resp);
    assert (c1 != 32'd0) else begin
      $display("Mismatch at %0t: cycle count read zero after a run", $time);
      errCount++;
    end
    axiRead(CycleAddr, c2, resp);
    checkEq("cycle count second read", c2, c1);
    testDone("halt and cycle count", errsAtStart);
  endtask

  // ----------------------------------------
  // main sequence
  // ----------------------------------------
  initial begin
    clk            = 1'b0;
    rst           <= 1'b1;
    busReq        <= '0;
    busReq.bready <= 1'b1;  // take responses at once
    busReq.rready <= 1'b1;
    lfsr           = 16'd62598;
    errCount       = 0;
    testCount      = 0;
    failedTests    = 0;
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    testBusBasics();
    testArith();
    testLoadUse();
    testBranch();
    testHalt();
    finishRun();
  end

endmodule

// File: design/pipelineCpu.sv
`timescale 1ns/10ps

module pipelineCpu
  import cpuPkg::*;
  import busPkg::*;
#(
  parameter int ImemDepth = 64,
  parameter int DmemDepth = 32
) (
  input  logic        clk,
  input  logic        rst,
  input  axiLiteReq_t busReq,
  output axiLiteRsp_t busRsp
);
  // debug side
  logic                run;
  logic                halted;
  logic                imemWe;
  logic [DbgIdxW-1:0]  imemAddr;
  logic [XLen-1:0]     imemData;
  logic [RegAddrW-1:0] regRdAddr;
  logic [XLen-1:0]     regRdData;
  logic [DbgIdxW-1:0]  dmemDbgAddr;
  logic                dmemDbgWe;
  logic [XLen-1:0]     dmemDbgData;
  logic [XLen-1:0]     dmemDbgRdData;

  // pipeline
  logic            stall;
  logic            redirect;
  logic [XLen-1:0] redirectPc;
  ifId_t           ifId;
  idEx_t           idEx;
  exMem_t          exMem;
  memWb_t          memWb;

  debugPort i_debugPort (
    .clk, .rst, .busReq, .busRsp, .regRdData, .dmemDbgRdData, .halted, .run,
    .imemWe, .imemAddr, .imemData, .regRdAddr, .dmemDbgAddr, .dmemDbgWe, .dmemDbgData
  );

  fetchStage #(.ImemDepth(ImemDepth)) i_fetch (
    .clk, .rst, .run, .stall, .redirect, .redirectPc, .imemWe, .imemAddr, .imemData, .ifId
  );

  decodeStage i_decode (
    .clk, .rst, .run, .ifId, .exMem, .memWb, .regRdAddr,
    .idEx, .stall, .redirect, .redirectPc, .regRdData
  );

  executeStage i_execute (.clk, .rst, .run, .idEx, .memWb, .exMem);

  memoryStage #(.DmemDepth(DmemDepth)) i_memory (
    .clk, .rst, .run, .exMem, .dmemDbgAddr, .dmemDbgWe, .dmemDbgData,
    .memWb, .dmemDbgRdData, .halted
  );

endmodule

// File: design/memoryStage.sv
`timescale 1ns/10ps

module memoryStage
  import cpuPkg::*;
  import busPkg::*;
#(
  parameter int DmemDepth = 32
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  exMem_t             exMem,
  input  logic [DbgIdxW-1:0] dmemDbgAddr,
  input  logic               dmemDbgWe,
  input  logic [XLen-1:0]    dmemDbgData,
  output memWb_t             memWb,
  output logic [XLen-1:0]    dmemDbgRdData,
  output logic               halted
);
  localparam int DmemAw = $clog2(DmemDepth);

  logic [XLen-1:0]   dmem [DmemDepth];
  logic [DmemAw-1:0] coreIdx;
  logic [DmemAw-1:0] dbgIdx;
  logic [XLen-1:0]   loadData;

  assign coreIdx       = exMem.aluResult[DmemAw+1:2];  // byte address / 4
  assign dbgIdx        = dmemDbgAddr[DmemAw-1:0];
  assign loadData      = dmem[coreIdx];
  assign dmemDbgRdData = dmem[dbgIdx];

  // core port while running, debug port otherwise
  always_ff @(posedge clk) begin
    if (run) begin
      if (exMem.memWrite) dmem[coreIdx] <= exMem.storeData;
    end else if (dmemDbgWe) begin
      dmem[dbgIdx] <= dmemDbgData;
    end
  end

  // ----------------------------------------
  // MEM/WB register and halt flag
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      memWb  <= '0;
      halted <= 1'b0;
    end else begin
      memWb.data     <= exMem.memRead ? loadData : exMem.aluResult;
      memWb.dest     <= exMem.dest;
      memWb.regWrite <= exMem.regWrite;
      memWb.halt     <= exMem.halt;
      if (memWb.halt) halted <= 1'b1;  // sticky until run drops
    end
  end

endmodule

// File: design/executeStage.sv
`timescale 1ns/10ps

module executeStage
  import cpuPkg::*;
(
  input  logic   clk,
  input  logic   rst,
  input  logic   run,
  input  idEx_t  idEx,
  input  memWb_t memWb,
  output exMem_t exMem
);
  logic [XLen-1:0] fwdA;
  logic [XLen-1:0] fwdB;
  logic [XLen-1:0] aluB;
  logic [XLen-1:0] aluOut;

  // ----------------------------------------
  // forwarding, newest result first
  // ----------------------------------------
  function automatic logic [XLen-1:0] forward(input logic [RegAddrW-1:0] idx,
                                              input logic [XLen-1:0] regVal);
    if (exMem.regWrite && exMem.dest != '0 && exMem.dest == idx) return exMem.aluResult;
    if (memWb.regWrite && memWb.dest != '0 && memWb.dest == idx) return memWb.data;
    return regVal;
  endfunction

  assign fwdA = forward(idEx.rs, idEx.operandA);
  assign fwdB = forward(idEx.rt, idEx.operandB);  // also the store data
  assign aluB = idEx.aluSrcImm ? idEx.imm : fwdB;

  always_comb begin
    case (idEx.aluOp)
      aluAdd:  aluOut = fwdA + aluB;  // also addresses for lw/sw
      aluSub:  aluOut = fwdA - aluB;
      aluAnd:  aluOut = fwdA & aluB;
      aluOr:   aluOut = fwdA | aluB;
      aluSlt:  aluOut = {{(XLen-1){1'b0}}, $signed(fwdA) < $signed(aluB)};
      default: aluOut = '0;
    endcase
  end

  // ----------------------------------------
  // EX/MEM register
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      exMem <= '0;
    end else begin
      exMem.aluResult <= aluOut;
      exMem.storeData <= fwdB;
      exMem.dest      <= idEx.dest;
      exMem.memRead   <= idEx.memRead;
      exMem.memWrite  <= idEx.memWrite;
      exMem.regWrite  <= idEx.regWrite;
      exMem.halt      <= idEx.halt;
    end
  end

endmodule

// File: design/decodeStage.sv
`timescale 1ns/10ps

module decodeStage
  import cpuPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  logic                run,
  input  ifId_t               ifId,
  input  exMem_t              exMem,
  input  memWb_t              memWb,
  input  logic [RegAddrW-1:0] regRdAddr,
  output idEx_t               idEx,
  output logic                stall,
  output logic                redirect,
  output logic [XLen-1:0]     redirectPc,
  output logic [XLen-1:0]     regRdData
);
  logic [XLen-1:0]     regFile [2**RegAddrW];
  opcode_t             opcode;
  logic [RegAddrW-1:0] rs;
  logic [RegAddrW-1:0] rt;
  logic [RegAddrW-1:0] rd;
  logic [XLen-1:0]     imm;
  logic [XLen-1:0]     rdA;
  logic [XLen-1:0]     rdB;
  logic [XLen-1:0]     brA;
  logic [XLen-1:0]     brB;
  idEx_t               ctrl;
  logic                isBranch;
  logic                isBne;
  logic                isJump;
  logic                loadUse;
  logic                branchOnEx;
  logic                branchOnLoad;

  assign opcode = opcode_t'(ifId.instr[31:26]);
  assign rs     = ifId.instr[25:21];
  assign rt     = ifId.instr[20:16];
  assign rd     = ifId.instr[15:11];
  assign imm    = {{(XLen-16){ifId.instr[15]}}, ifId.instr[15:0]};

  // ----------------------------------------
  // register file
  // ----------------------------------------
  // r0 reads zero, same-cycle writeback is bypassed
  function automatic logic [XLen-1:0] readReg(input logic [RegAddrW-1:0] idx);
    if (idx == '0) return '0;
    if (memWb.regWrite && memWb.dest == idx) return memWb.data;
    return regFile[idx];
  endfunction

  always_ff @(posedge clk) begin
    if (memWb.regWrite && memWb.dest != '0) regFile[memWb.dest] <= memWb.data;
  end

  assign rdA       = readReg(rs);
  assign rdB       = readReg(rt);
  assign regRdData = readReg(regRdAddr);  // debug readback

  // ----------------------------------------
  // control decode
  // ----------------------------------------
  always_comb begin
    ctrl          = '0;
    ctrl.operandA = rdA;
    ctrl.operandB = rdB;
    ctrl.imm      = imm;
    ctrl.rs       = rs;
    ctrl.rt       = rt;
    ctrl.dest     = rt;  // I-type default
    isBranch      = 1'b0;
    isBne         = 1'b0;
    isJump        = 1'b0;
    case (opcode)
      opRType: begin
        ctrl.dest     = rd;
        ctrl.regWrite = 1'b1;
        case (funct_t'(ifId.instr[5:0]))
          fnAdd:   ctrl.aluOp = aluAdd;
          fnSub:   ctrl.aluOp = aluSub;
          fnAnd:   ctrl.aluOp = aluAnd;
          fnOr:    ctrl.aluOp = aluOr;
          fnSlt:   ctrl.aluOp = aluSlt;
          default: ctrl.regWrite = 1'b0;  // all-zero word is a nop
        endcase
      end
      opAddi: begin
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opLw: begin
        ctrl.memRead   = 1'b1;
        ctrl.regWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opSw: begin
        ctrl.memWrite  = 1'b1;
        ctrl.aluSrcImm = 1'b1;
      end
      opBeq: isBranch = 1'b1;
      opBne: begin
        isBranch = 1'b1;
        isBne    = 1'b1;
      end
      opJ:    isJump = 1'b1;
      opHalt: ctrl.halt = 1'b1;
      default: ;
    endcase
  end

  // ----------------------------------------
  // branch resolve and hazards
  // ----------------------------------------
  assign brA = (exMem.regWrite && exMem.dest != '0 && exMem.dest == rs) ? exMem.aluResult : rdA;
  assign brB = (exMem.regWrite && exMem.dest != '0 && exMem.dest == rt) ? exMem.aluResult : rdB;

  assign loadUse      = idEx.memRead && idEx.dest != '0 && (idEx.dest == rs || idEx.dest == rt);
  assign branchOnEx   = isBranch && idEx.regWrite && idEx.dest != '0 &&
                        (idEx.dest == rs || idEx.dest == rt);
  assign branchOnLoad = isBranch && exMem.memRead && exMem.dest != '0 &&
                        (exMem.dest == rs || exMem.dest == rt);  // second bubble
  assign stall        = loadUse || branchOnEx || branchOnLoad;

  assign redirect   = !stall && (isJump || (isBranch && ((brA == brB) != isBne)));
  assign redirectPc = isJump ? {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00}
                             : ifId.pcPlus4 + {imm[XLen-3:0], 2'b00};

  always_ff @(posedge clk) begin
    if (rst || !run || stall) idEx <= '0;  // bubble on stall
    else idEx <= ctrl;
  end

endmodule

// File: design/fetchStage.sv
`timescale 1ns/10ps

module fetchStage
  import cpuPkg::*;
  import busPkg::*;
#(
  parameter int ImemDepth = 64
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               run,
  input  logic               stall,
  input  logic               redirect,
  input  logic [XLen-1:0]    redirectPc,
  input  logic               imemWe,
  input  logic [DbgIdxW-1:0] imemAddr,
  input  logic [XLen-1:0]    imemData,
  output ifId_t              ifId
);
  localparam int ImemAw = $clog2(ImemDepth);

  logic [XLen-1:0] imem [ImemDepth];
  logic [XLen-1:0] pc;
  logic [XLen-1:0] pcPlus4;
  logic [XLen-1:0] fetched;
  logic            fetchHalt;
  logic            frozen;   // halt already fetched

  assign fetched   = imem[pc[ImemAw+1:2]];  // word index
  assign pcPlus4   = pc + 32'd4;
  assign fetchHalt = opcode_t'(fetched[31:26]) == opHalt;

  // program load from the debug port
  always_ff @(posedge clk) begin
    if (imemWe) imem[imemAddr[ImemAw-1:0]] <= imemData;
  end

  // ----------------------------------------
  // pc and IF/ID
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (rst || !run) begin
      pc     <= '0;
      ifId   <= '0;
      frozen <= 1'b0;
    end else if (redirect) begin
      pc   <= redirectPc;
      ifId <= '0;  // squash the wrong-path fetch
    end else if (!stall) begin
      if (frozen) begin
        ifId <= '0;  // nops behind the halt
      end else begin
        ifId <= '{instr: fetched, pcPlus4: pcPlus4};
        if (fetchHalt) frozen <= 1'b1;
        else pc <= pcPlus4;
      end
    end
  end

endmodule

// File: design/debugPort.sv
`timescale 1ns/10ps

module debugPort
  import cpuPkg::*;
  import busPkg::*;
(
  input  logic                clk,
  input  logic                rst,
  input  axiLiteReq_t         busReq,
  output axiLiteRsp_t         busRsp,
  input  logic [XLen-1:0]     regRdData,
  input  logic [XLen-1:0]     dmemDbgRdData,
  input  logic                halted,
  output logic                run,
  output logic                imemWe,
  output logic [DbgIdxW-1:0]  imemAddr,
  output logic [XLen-1:0]     imemData,
  output logic [RegAddrW-1:0] regRdAddr,
  output logic [DbgIdxW-1:0]  dmemDbgAddr,
  output logic                dmemDbgWe,
  output logic [XLen-1:0]     dmemDbgData
);
  logic            bValid;
  logic            rValid;
  logic [XLen-1:0] rData;
  logic [XLen-1:0] rdMux;
  logic [XLen-1:0] cycleCnt;
  logic            wrFire;
  logic            wrFull;
  logic            rdFire;
  logic [3:0]      wrRegion;
  logic [3:0]      rdRegion;

  // ----------------------------------------
  // write channel
  // ----------------------------------------
  assign wrFire   = busReq.awvalid && busReq.wvalid && !bValid;
  assign wrFull   = wrFire && (&busReq.wstrb);  // partial words are dropped
  assign wrRegion = busReq.awaddr[15:12];
  assign rdRegion = busReq.araddr[15:12];

  assign imemWe      = wrFull && wrRegion == ImemBase[15:12];
  assign imemAddr    = busReq.awaddr[DbgIdxW+1:2];
  assign imemData    = busReq.wdata;
  assign dmemDbgWe   = wrFull && wrRegion == DmemBase[15:12] && !run;  // core owns dmem
  assign dmemDbgData = busReq.wdata;
  // one dmem address, shared by debug write and readback
  assign dmemDbgAddr = dmemDbgWe ? busReq.awaddr[DbgIdxW+1:2] : busReq.araddr[DbgIdxW+1:2];
  assign regRdAddr   = busReq.araddr[RegAddrW+1:2];

  // a dmem write this cycle holds off the read
  assign rdFire = busReq.arvalid && !rValid && !dmemDbgWe;

  // ----------------------------------------
  // read decode
  // ----------------------------------------
  always_comb begin
    rdMux = '0;  // unmapped
    case (rdRegion)
      CtrlAddr[15:12]: begin
        if (busReq.araddr == CtrlAddr) rdMux = {{(XLen-1){1'b0}}, run};
        else if (busReq.araddr == StatusAddr) rdMux = {{(XLen-1){1'b0}}, halted};
        else if (busReq.araddr == CycleAddr) rdMux = cycleCnt;
      end
      RegBase[15:12]: begin
        if (busReq.araddr[11:RegAddrW+2] == '0) rdMux = regRdData;  // only 32 regs
      end
      DmemBase[15:12]: rdMux = dmemDbgRdData;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      run      <= 1'b0;
      bValid   <= 1'b0;
      rValid   <= 1'b0;
      cycleCnt <= '0;
    end else begin
      if (wrFull && busReq.awaddr == CtrlAddr) run <= busReq.wdata[0];
      if (wrFire) bValid <= 1'b1;
      else if (busReq.bready) bValid <= 1'b0;
      if (rdFire) rValid <= 1'b1;
      else if (busReq.rready) rValid <= 1'b0;
      if (run && !halted) cycleCnt <= cycleCnt + 1'b1;  // counts only live cycles
    end
  end

  always_ff @(posedge clk) begin
    if (rdFire) rData <= rdMux;
  end

  always_comb begin
    busRsp.awready = wrFire;  // single-cycle accept
    busRsp.wready  = wrFire;
    busRsp.bvalid  = bValid;
    busRsp.bresp   = RespOkay;
    busRsp.arready = rdFire;
    busRsp.rdata   = rData;
    busRsp.rresp   = RespOkay;
    busRsp.rvalid  = rValid;
  end

endmodule

// File: design/busPkg.sv
package busPkg;

  typedef struct packed {
    logic [15:0] awaddr;
    logic        awvalid;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        bready;
    logic [15:0] araddr;
    logic        arvalid;
    logic        rready;
  } axiLiteReq_t;

  typedef struct packed {
    logic        awready;
    logic        wready;
    logic        bvalid;
    logic [1:0]  bresp;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
  } axiLiteRsp_t;

  localparam logic [1:0] RespOkay = 2'b00;

  // ----------------------------------------
  // debug address map, word = base + 4*index
  // ----------------------------------------
  localparam logic [15:0] CtrlAddr   = 16'h0000;  // bit 0 run
  localparam logic [15:0] StatusAddr = 16'h0004;  // bit 0 halted
  localparam logic [15:0] CycleAddr  = 16'h0008;
  localparam logic [15:0] ImemBase   = 16'h1000;
  localparam logic [15:0] RegBase    = 16'h2000;
  localparam logic [15:0] DmemBase   = 16'h3000;

  localparam int DbgIdxW = 10;  // word index inside a 4 KB region

endpackage

// File: design/cpuPkg.sv
package cpuPkg;

  localparam int XLen     = 32;  // datapath width
  localparam int RegAddrW = 5;   // 32 registers

  // ----------------------------------------
  // instruction set
  // ----------------------------------------
  typedef enum logic [5:0] {
    opRType = 6'd0,
    opJ     = 6'd2,
    opBeq   = 6'd4,
    opBne   = 6'd5,
    opAddi  = 6'd8,
    opLw    = 6'd35,
    opSw    = 6'd43,
    opHalt  = 6'd63   // stops fetch
  } opcode_t;

  typedef enum logic [5:0] {
    fnAdd = 6'd32,
    fnSub = 6'd34,
    fnAnd = 6'd36,
    fnOr  = 6'd37,
    fnSlt = 6'd42
  } funct_t;

  typedef enum logic [2:0] {
    aluAdd,  // zero value, so a bubble adds
    aluSub,
    aluAnd,
    aluOr,
    aluSlt
  } aluOp_t;

  // ----------------------------------------
  // pipeline registers
  // ----------------------------------------
  typedef struct packed {
    logic [XLen-1:0] instr;
    logic [XLen-1:0] pcPlus4;   // base for branch targets
  } ifId_t;

  typedef struct packed {
    logic [XLen-1:0]     operandA;
    logic [XLen-1:0]     operandB;
    logic [XLen-1:0]     imm;       // sign-extended
    logic [RegAddrW-1:0] rs;
    logic [RegAddrW-1:0] rt;
    logic [RegAddrW-1:0] dest;
    aluOp_t              aluOp;
    logic                aluSrcImm;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    logic                halt;
  } idEx_t;

  typedef struct packed {
    logic [XLen-1:0]     aluResult;  // also the load/store address
    logic [XLen-1:0]     storeData;
    logic [RegAddrW-1:0] dest;
    logic                memRead;
    logic                memWrite;
    logic                regWrite;
    logic                halt;
  } exMem_t;

  typedef struct packed {
    logic [XLen-1:0]     data;
    logic [RegAddrW-1:0] dest;
    logic                regWrite;
    logic                halt;
  } memWb_t;

endpackage
